/* src.f */
+incdir+.
bpPkg.sv
predIf.sv
hybridControl.sv
localPredictor.sv
globalPredictor.sv
choicePredictor.sv
branchPredictorTop.sv
tbBranchPredictor.sv

/* runSim.sh */
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tbBranchPredictor -f src.f -o simBranchPredictor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simBranchPredictor > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

echo "Run completed without failure"
exit 0

/* tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference copy of the predictor state kept in step with the DUT
logic [historyBits-1:0] historyModel [tableDepth];   // Per-address local history
logic [counterBits-1:0] patternModel [patternDepth]; // Local counters indexed by history
logic [counterBits-1:0] gshareModel [tableDepth];
logic [counterBits-1:0] chooserModel [tableDepth];   // MSB set picks gshare
logic [historyBits-1:0] ghrModel;

function automatic logic isCondBranch(input logic [31:0] instr);
    logic [5:0] op;
    logic [4:0] rt;
    op = instr[31:26];
    rt = instr[20:16];
    if (op == opRegimm) begin
        return (rt == rtBltz) || (rt == rtBgez) || (rt == rtBltzal) || (rt == rtBgezal);
    end
    return (op == opBeq) || (op == opBne) || (op == opBlez) || (op == opBgtz);
endfunction

function automatic logic [counterBits-1:0] stepCounter(input logic [counterBits-1:0] count,
                                                       input logic up);
    if (up) begin
        return (count == '1) ? count : count + counterBits'(1);
    end
    return (count == '0) ? count : count - counterBits'(1);
endfunction

function automatic void clearTables();
    for (int i = 0; i < tableDepth; i++) begin
        historyModel[i] = '0;
        gshareModel[i] = counterInit;
        chooserModel[i] = choiceInit;
    end
    for (int i = 0; i < patternDepth; i++) begin
        patternModel[i] = counterInit;
    end
    ghrModel = '0;
endfunction

// Chooser-selected direction from the current state
function automatic logic predictFromTables(input logic [31:0] addr);
    logic [indexBits-1:0] idx;
    logic                 localBit;
    logic                 globalBit;
    idx = addr[indexBits+1:2];
    localBit = patternModel[historyModel[idx]][counterBits-1];
    globalBit = gshareModel[idx ^ ghrModel][counterBits-1];
    return chooserModel[idx][counterBits-1] ? globalBit : localBit;
endfunction

// Every read below sees the state from before this edge
function automatic void trainTables(input logic [31:0] addr, input logic outcome);
    logic [indexBits-1:0]   idx;
    logic [indexBits-1:0]   gIdx;
    logic [historyBits-1:0] oldHistory;
    logic                   localBit;
    logic                   globalBit;
    idx = addr[indexBits+1:2];
    gIdx = idx ^ ghrModel;
    oldHistory = historyModel[idx];
    localBit = patternModel[oldHistory][counterBits-1];
    globalBit = gshareModel[gIdx][counterBits-1];
    if (localBit != globalBit) begin
        chooserModel[idx] = stepCounter(chooserModel[idx], globalBit == outcome);
    end
    patternModel[oldHistory] = stepCounter(patternModel[oldHistory], outcome);
    historyModel[idx] = {oldHistory[historyBits-2:0], outcome};
    gshareModel[gIdx] = stepCounter(gshareModel[gIdx], outcome);
    ghrModel = {ghrModel[historyBits-2:0], outcome};
endfunction

`endif

/* tbBranchPredictor.sv */
`timescale 1ns/100ps

module tbBranchPredictor
    import bpPkg::*;
();

    localparam int resetCycles = 16;
    localparam int minCycles = 3000;
    localparam int maxCycles = 40000;     // Upper bound of the main run
    localparam int poolSize = 16;

    logic        CLK;
    logic        RESET;
    logic        FLUSH;
    logic [31:0] InstrInput;
    logic [31:0] InstrAddr;
    logic        BranchResolved;
    logic [31:0] BranchResolvedAddr;
    logic        Taken;

    logic [31:0] addrPool [poolSize];     // Small pool so entries get reused
    logic        alternateState [poolSize];
    logic        expectedTaken;
    int          takenSeen;
    int          flushSeen;
    int          zeroSeen;
    int          globalChosen;            // Branches where the chooser picked gshare
    int          cycleCount;

    `include "tbModel.svh"

    branchPredictorTop uut (
        .CLK                (CLK),
        .RESET              (RESET),
        .FLUSH              (FLUSH),
        .InstrInput         (InstrInput),
        .InstrAddr          (InstrAddr),
        .BranchResolved     (BranchResolved),
        .BranchResolvedAddr (BranchResolvedAddr),
        .Taken              (Taken)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic expectTaken(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: Taken is %b, expected %b, %s",
                     $time, actual, expected, what);
            $display("SIMULATION FAILED");
            $fatal(1, "Taken mismatch");
        end
    endtask

    task automatic compareHistory(input logic [historyBits-1:0] actual,
                                  input logic [historyBits-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: global history is %h, expected %h",
                     $time, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Global history mismatch");
        end
    endtask

    task automatic stopOnTimeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    endtask

    // About 60 percent branches and the rest plain opcodes or REGIMM with other rt
    function automatic logic [31:0] makeInstruction();
        logic [5:0] op;
        logic [4:0] rt;
        int         kind;
        kind = $urandom_range(0, 9);
        rt = 5'($urandom);
        if (kind < 6) begin
            case ($urandom_range(0, 7))
                0: begin
                    op = opRegimm;
                    rt = rtBltz;
                end
                1: begin
                    op = opRegimm;
                    rt = rtBgez;
                end
                2: begin
                    op = opRegimm;
                    rt = rtBltzal;
                end
                3: begin
                    op = opRegimm;
                    rt = rtBgezal;
                end
                4: op = opBeq;
                5: op = opBne;
                6: op = opBlez;
                default: op = opBgtz;
            endcase
        end else if (kind < 8) begin
            op = opRegimm;
            if ($urandom_range(0, 1) == 0) begin
                rt = 5'($urandom_range(2, 15));
            end else begin
                rt = 5'($urandom_range(18, 31));
            end
        end else if (kind == 8) begin
            op = 6'($urandom_range(8, 63));
        end else begin
            op = 6'd0;                    // SPECIAL group
        end
        return {op, 5'($urandom), rt, 16'($urandom)};
    endfunction

    // Each pool slot is always taken, alternating, mostly taken or mostly not
    function automatic logic drawOutcome(input int slot);
        case (slot % 4)
            0: return 1'b1;
            1: begin
                alternateState[slot] = !alternateState[slot];
                return alternateState[slot];
            end
            2: return $urandom_range(0, 99) < 85;
            default: return $urandom_range(0, 99) < 15;
        endcase
    endfunction

    task automatic driveNextInputs();
        int slot;
        slot = $urandom_range(0, poolSize - 1);
        InstrInput <= makeInstruction();
        InstrAddr <= addrPool[slot];
        FLUSH <= $urandom_range(0, 99) < 5;
        if ($urandom_range(0, 99) < 85) begin
            slot = $urandom_range(0, poolSize - 1);
            BranchResolvedAddr <= addrPool[slot];
            BranchResolved <= drawOutcome(slot);
        end else begin
            BranchResolvedAddr <= 32'd0;
            BranchResolved <= 1'($urandom_range(0, 1)); // Must be ignored
        end
    endtask

    task automatic runCycle();
        logic isBranchNow;
        @(posedge CLK);
        // Inputs held since the last edge are the ones sampled now
        isBranchNow = isCondBranch(InstrInput);
        if (FLUSH) begin
            expectedTaken = 1'b0;
            flushSeen++;
        end else begin
            expectedTaken = isBranchNow && predictFromTables(InstrAddr);
            if (isBranchNow && chooserModel[InstrAddr[indexBits+1:2]][counterBits-1]) begin
                globalChosen++;
            end
            if (BranchResolvedAddr == 32'd0) begin
                zeroSeen++;
            end else begin
                trainTables(BranchResolvedAddr, BranchResolved);
            end
        end
        if (expectedTaken) begin
            takenSeen++;
        end
        driveNextInputs();
        @(negedge CLK);
        expectTaken(Taken, expectedTaken, "prediction one cycle after fetch");
        compareHistory(uut.controlUnit.globalHistory, ghrModel);
    endtask

    initial begin
        RESET <= 1'b0;
        FLUSH <= 1'b0;
        InstrInput <= 32'd0;
        InstrAddr <= 32'd0;
        BranchResolved <= 1'b0;
        BranchResolvedAddr <= 32'd0;
        void'($urandom(99));
        takenSeen = 0;
        flushSeen = 0;
        zeroSeen = 0;
        globalChosen = 0;
        for (int i = 0; i < poolSize; i++) begin
            addrPool[i] = 32'h0040_0000 | ($urandom & 32'h0000_fffc);
            alternateState[i] = 1'b0;
        end
        clearTables();

        for (int c = 0; c < resetCycles; c++) begin
            @(posedge CLK);
            if (c == resetCycles - 1) begin
                RESET <= 1'b1;
            end
            @(negedge CLK);
            expectTaken(Taken, 1'b0, "during reset");
            compareHistory(uut.controlUnit.globalHistory, '0);
        end

        // Run until every behavior has been exercised enough
        cycleCount = 0;
        while (!(cycleCount >= minCycles && takenSeen >= 50 && flushSeen >= 20 &&
                 zeroSeen >= 20 && globalChosen >= 5)) begin
            if (cycleCount >= maxCycles) begin
                stopOnTimeout("coverage targets of the main run");
            end
            runCycle();
            cycleCount++;
        end

        $display("Ran %0d cycles: %0d taken, %0d flushes, %0d zero updates, %0d gshare picks",
                 cycleCount, takenSeen, flushSeen, zeroSeen, globalChosen);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* branchPredictorTop.sv */
`timescale 1ns/100ps

// Tournament predictor with local and gshare behind a per-address chooser
module branchPredictorTop (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        FLUSH,
    input  logic [31:0] InstrInput,          // Instruction in fetch
    input  logic [31:0] InstrAddr,           // Its address
    input  logic        BranchResolved,      // Resolved direction
    input  logic [31:0] BranchResolvedAddr,  // Zero means no update
    output logic        Taken                // Registered prediction
);

    predIf localBus ();
    predIf globalBus ();
    predIf choiceBus ();

    hybridControl controlUnit (
        .CLK                (CLK),
        .RESET              (RESET),
        .FLUSH              (FLUSH),
        .InstrInput         (InstrInput),
        .InstrAddr          (InstrAddr),
        .BranchResolved     (BranchResolved),
        .BranchResolvedAddr (BranchResolvedAddr),
        .Taken              (Taken),
        .localPort          (localBus.ctrl),
        .globalPort         (globalBus.ctrl),
        .choicePort         (choiceBus.ctrl)
    );

    localPredictor localTable (
        .CLK   (CLK),
        .RESET (RESET),
        .port  (localBus.tableSide)
    );

    globalPredictor globalTable (
        .CLK   (CLK),
        .RESET (RESET),
        .port  (globalBus.tableSide)
    );

    choicePredictor choiceTable (
        .CLK   (CLK),
        .RESET (RESET),
        .port  (choiceBus.tableSide)
    );

endmodule

/* choicePredictor.sv */
`timescale 1ns/100ps

module choicePredictor
    import bpPkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    predIf.tableSide port
);

    // Per-address chooser whose set MSB means trust the gshare side
    logic [counterBits-1:0] choiceTable [tableDepth];

    logic [counterBits-1:0] currentChoice;
    logic [counterBits-1:0] nextChoice;

    assign port.lookupBit = choiceTable[port.lookupIndex][counterBits-1];

    assign currentChoice = choiceTable[port.updateIndex];
    assign port.updateBit = currentChoice[counterBits-1];

    // updateTaken high means global was the correct one
    always_comb begin
        nextChoice = currentChoice;
        if (port.updateTaken) begin
            if (currentChoice != 2'b11) begin
                nextChoice = currentChoice + 2'b01;
            end
        end else begin
            if (currentChoice != 2'b00) begin
                nextChoice = currentChoice - 2'b01;
            end
        end
    end

    // Strobe is only raised on a disagreement
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < tableDepth; i++) begin
                choiceTable[i] <= choiceInit;
            end
        end else if (port.updateEn) begin
            choiceTable[port.updateIndex] <= nextChoice;
        end
    end

endmodule

/* globalPredictor.sv */
`timescale 1ns/100ps

module globalPredictor
    import bpPkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    predIf.tableSide port
);

    // Gshare counters indexed by an address already hashed with global history
    logic [counterBits-1:0] counterTable [tableDepth];

    logic [counterBits-1:0] updateCount;
    logic [counterBits-1:0] nextCount;

    assign port.lookupBit = counterTable[port.lookupIndex][counterBits-1];

    assign updateCount = counterTable[port.updateIndex];
    assign port.updateBit = updateCount[counterBits-1];    // Seen before the write

    always_comb begin
        nextCount = updateCount;
        if (port.updateTaken && updateCount != 2'b11) begin
            nextCount = updateCount + 2'b01;   // Toward strongly taken
        end else if (!port.updateTaken && updateCount != 2'b00) begin
            nextCount = updateCount - 2'b01;   // Toward strongly not-taken
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < tableDepth; i++) begin
                counterTable[i] <= counterInit;
            end
        end else if (port.updateEn) begin
            counterTable[port.updateIndex] <= nextCount;
        end
    end

endmodule

/* localPredictor.sv */
`timescale 1ns/100ps

module localPredictor
    import bpPkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    predIf.tableSide port
);

    logic [historyBits-1:0] historyTable [tableDepth];     // Per-address history
    logic [counterBits-1:0] patternTable [patternDepth];   // Counters indexed by history

    logic [historyBits-1:0] lookupHistory;
    logic [historyBits-1:0] updateHistory;
    logic [counterBits-1:0] updateCount;
    logic [counterBits-1:0] nextCount;

    // Address selects the history and the history selects the counter
    assign lookupHistory = historyTable[port.lookupIndex];
    assign port.lookupBit = patternTable[lookupHistory][counterBits-1];

    assign updateHistory = historyTable[port.updateIndex];
    assign updateCount = patternTable[updateHistory];
    assign port.updateBit = updateCount[counterBits-1];

    // Saturating step toward the resolved direction
    always_comb begin
        nextCount = updateCount;
        if (port.updateTaken) begin
            if (updateCount != 2'b11) begin
                nextCount = updateCount + 2'b01;
            end
        end else if (updateCount != 2'b00) begin
            nextCount = updateCount - 2'b01;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < patternDepth; i++) begin
                patternTable[i] <= counterInit;
            end
        end else if (port.updateEn) begin
            patternTable[updateHistory] <= nextCount;   // Counter at the old history
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < tableDepth; i++) begin
                historyTable[i] <= '0;
            end
        end else if (port.updateEn) begin
            historyTable[port.updateIndex] <=
                {updateHistory[historyBits-2:0], port.updateTaken}; // Outcome into LSB
        end
    end

endmodule

/* hybridControl.sv */
`timescale 1ns/100ps

module hybridControl
    import bpPkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        FLUSH,
    input  logic [31:0] InstrInput,
    input  logic [31:0] InstrAddr,
    input  logic        BranchResolved,
    input  logic [31:0] BranchResolvedAddr,
    output logic        Taken,
    predIf.ctrl         localPort,
    predIf.ctrl         globalPort,
    predIf.ctrl         choicePort
);

    logic [5:0]             opcode;
    logic [4:0]             rtField;
    logic                   isBranch;
    logic [historyBits-1:0] globalHistory;     // Newest outcome in the LSB
    logic [indexBits-1:0]   lookupAddrIndex;
    logic [indexBits-1:0]   updateAddrIndex;
    logic                   updateValid;
    logic                   predictorsDisagree;
    logic                   selectedPrediction;

    assign opcode = InstrInput[31:26];
    assign rtField = InstrInput[20:16];         // Only meaningful for REGIMM

    // Conditional branch decode
    always_comb begin
        case (opcode)
            opRegimm: begin
                isBranch = rtField inside {rtBltz, rtBgez, rtBltzal, rtBgezal};
            end
            opBeq, opBne, opBlez, opBgtz: begin
                isBranch = 1'b1;
            end
            default: begin
                isBranch = 1'b0;                // Not a conditional branch
            end
        endcase
    end

    assign lookupAddrIndex = InstrAddr[indexBits+1:2];
    assign updateAddrIndex = BranchResolvedAddr[indexBits+1:2];

    // A zero resolved address carries no branch
    assign updateValid = (BranchResolvedAddr != 32'd0) && !FLUSH;

    // Local and chooser tables are indexed by address alone
    assign localPort.lookupIndex = lookupAddrIndex;
    assign localPort.updateIndex = updateAddrIndex;
    assign choicePort.lookupIndex = lookupAddrIndex;
    assign choicePort.updateIndex = updateAddrIndex;

    // Gshare update index uses the history from before this edge's shift
    assign globalPort.lookupIndex = lookupAddrIndex ^ globalHistory;
    assign globalPort.updateIndex = updateAddrIndex ^ globalHistory;

    assign localPort.updateEn = updateValid;
    assign globalPort.updateEn = updateValid;
    assign localPort.updateTaken = BranchResolved;
    assign globalPort.updateTaken = BranchResolved;

    // Chooser only learns when the two predictors pointed different ways
    assign predictorsDisagree = localPort.updateBit != globalPort.updateBit;
    assign choicePort.updateEn = updateValid && predictorsDisagree;
    assign choicePort.updateTaken = globalPort.updateBit == BranchResolved; // Global was right

    assign selectedPrediction = choicePort.lookupBit ? globalPort.lookupBit
                                                     : localPort.lookupBit;

    // Prediction registered one cycle after the instruction is sampled
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            Taken <= 1'b0;
        end else if (FLUSH) begin
            Taken <= 1'b0;                      // Flushed fetch predicts nothing
        end else begin
            Taken <= isBranch && selectedPrediction;
        end
    end

    // Global history shifts at the same edge as the table updates
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            globalHistory <= '0;
        end else if (updateValid) begin
            globalHistory <= {globalHistory[historyBits-2:0], BranchResolved};
        end
    end

endmodule

/* predIf.sv */
`timescale 1ns/100ps

// Link between the control module and one counter table
interface predIf
    import bpPkg::*;
();
    logic [indexBits-1:0] lookupIndex;   // Index for this cycle's prediction
    logic                 lookupBit;     // Counter MSB at lookupIndex
    logic [indexBits-1:0] updateIndex;   // Index of the resolved branch
    logic                 updateBit;     // Counter MSB at updateIndex before update
    logic                 updateEn;      // One-cycle write strobe
    logic                 updateTaken;   // Direction to step the counter

    modport ctrl (
        output lookupIndex,
        output updateIndex,
        output updateEn,
        output updateTaken,
        input  lookupBit,
        input  updateBit
    );

    modport tableSide (
        input  lookupIndex,
        input  updateIndex,
        input  updateEn,
        input  updateTaken,
        output lookupBit,
        output updateBit
    );

endinterface

/* bpPkg.sv */
package bpPkg;

    // Table geometry
    localparam int indexBits = 10;                // Address bits 11:2
    localparam int historyBits = 10;              // Local and global history width
    localparam int tableDepth = 1 << indexBits;   // Entries per address-indexed table
    localparam int patternDepth = 1 << historyBits; // Local pattern counters
    localparam int counterBits = 2;               // Saturating counter width

    // Primary opcodes of conditional branches
    localparam logic [5:0] opRegimm = 6'b000001;  // BLTZ/BGEZ family decoded by rt
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opBlez = 6'b000110;
    localparam logic [5:0] opBgtz = 6'b000111;

    // REGIMM rt codes that are branches
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    // Counter reset values
    // The MSB is the prediction; for the chooser it means prefer global
    localparam logic [counterBits-1:0] counterInit = 2'b01; // Weakly not-taken
    localparam logic [counterBits-1:0] choiceInit = 2'b01;  // Weakly prefer local

endpackage
